/* list.f */
hw/priv_pkg.sv
hw/sys_decode.sv
hw/irq_arbiter.sv
hw/csr_file.sv
hw/priv_ctrl.sv
hw/priv_unit.sv
tb/priv_unit_sva.sv
tb/priv_unit_tb.sv

/* run.sh */
#!/bin/sh
# build and run the priv_unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module priv_unit_tb \
   -o sim_priv_unit || exit 1

./obj_dir/sim_priv_unit > sim.log 2>&1
cat sim.log
grep -qx "test passed" sim.log && exit 0 || exit 1

/* tb/priv_unit_tb.sv */
`timescale 1ns/1ps

module priv_unit_tb;
   import priv_pkg::*;

   localparam xlen_t HART_ID    = 32'h0000_0005;
   localparam xlen_t MISA_VALUE = 32'h4000_0100;
   localparam int    NUM_CMDS   = 371;
   localparam int    LIMIT      = NUM_CMDS * 4 + 100;

   localparam logic [2:0] F_RW  = 3'd1;
   localparam logic [2:0] F_RS  = 3'd2;
   localparam logic [2:0] F_RC  = 3'd3;
   localparam logic [2:0] F_RWI = 3'd5;
   localparam logic [2:0] F_RSI = 3'd6;
   localparam logic [2:0] F_RCI = 3'd7;

   localparam logic [31:0] I_ECALL  = 32'h0000_0073;
   localparam logic [31:0] I_EBREAK = 32'h0010_0073;
   localparam logic [31:0] I_MRET   = 32'h3020_0073;

   logic     clk;
   logic     rstn;
   sys_cmd_t cmd;
   irq_t     irq;
   logic     cmd_ready;
   sys_rsp_t rsp;

   sys_rsp_t exp_q[$];
   string    name_q[$];
   int       cycles;

   // model of the machine CSR state
   logic  m_mie_b;
   logic  m_mpie_b;
   xlen_t m_mie;
   xlen_t m_mtvec;
   xlen_t m_mscratch;
   xlen_t m_mepc;
   xlen_t m_mcause;
   xlen_t m_mtval;

   priv_unit #(
      .HART_ID    (HART_ID),
      .MISA_VALUE (MISA_VALUE)
   ) DUT (
      .clk       (clk),
      .rstn      (rstn),
      .cmd       (cmd),
      .irq       (irq),
      .cmd_ready (cmd_ready),
      .rsp       (rsp)
   );

   always #20 clk = ~clk;

   //////////////////////////////////////////////////
   // reference model
   //////////////////////////////////////////////////
   function automatic logic ref_read(input csr_addr_t a, input irq_t q, output xlen_t v);
      logic known;
      known = 1'b1;
      v     = '0;
      case (a)
         CSR_MSTATUS:  v = 32'h0000_1800 | {24'd0, m_mpie_b, 3'd0, m_mie_b, 3'd0};
         CSR_MISA:     v = MISA_VALUE;
         CSR_MIE:      v = m_mie;
         CSR_MTVEC:    v = m_mtvec;
         CSR_MSCRATCH: v = m_mscratch;
         CSR_MEPC:     v = m_mepc;
         CSR_MCAUSE:   v = m_mcause;
         CSR_MTVAL:    v = m_mtval;
         CSR_MIP:      v = {20'd0, q.ext, 3'd0, q.timer, 3'd0, q.sw, 3'd0};
         CSR_MHARTID:  v = HART_ID;
         default:      known = 1'b0;
      endcase
      return known;
   endfunction

   function automatic void ref_write(input csr_addr_t a, input xlen_t v);
      case (a)
         CSR_MSTATUS: begin
            m_mie_b  = v[3];
            m_mpie_b = v[7];
         end
         CSR_MIE:      m_mie = v & 32'h0000_0888;
         CSR_MTVEC: begin
            // reserved modes leave mtvec alone
            if (!v[1]) begin
               m_mtvec = v;
            end
         end
         CSR_MSCRATCH: m_mscratch = v;
         CSR_MEPC:     m_mepc = {v[31:2], 2'b00};
         CSR_MCAUSE:   m_mcause = v;
         CSR_MTVAL:    m_mtval = v;
         default: begin
         end
      endcase
   endfunction

   function automatic sys_rsp_t predict(input logic [31:0] ins, input xlen_t pc,
                                        input xlen_t rs1v, input irq_t q);
      sys_rsp_t   r;
      logic [6:0] opc;
      logic [2:0] f3;
      logic [4:0] rd;
      logic [4:0] rs1f;
      csr_addr_t  imm;
      logic [4:0] cause;
      logic       take_irq;
      logic       is_trap;
      logic       known;
      logic       ro;
      logic       rd_en;
      logic       wr_en;
      xlen_t      old;
      xlen_t      src;
      xlen_t      nv;
      xlen_t      tval;
      xlen_t      base;
      opc       = ins[6:0];
      f3        = ins[14:12];
      rd        = ins[11:7];
      rs1f      = ins[19:15];
      imm       = ins[31:20];
      r         = '0;
      r.valid   = 1'b1;
      r.rd_addr = rd;
      r.next_pc = pc + 32'd4;
      base      = {m_mtvec[31:2], 2'b00};
      is_trap   = 1'b0;
      take_irq  = 1'b0;
      tval      = '0;
      cause     = 5'd0;
      // ext, then sw, then timer
      if (m_mie_b) begin
         if (q.ext && m_mie[11]) begin
            take_irq = 1'b1;
            cause    = 5'd11;
         end else if (q.sw && m_mie[3]) begin
            take_irq = 1'b1;
            cause    = 5'd3;
         end else if (q.timer && m_mie[7]) begin
            take_irq = 1'b1;
            cause    = 5'd7;
         end
      end
      if (take_irq) begin
         is_trap = 1'b1;
      end else if (opc == 7'h73 && f3 == 3'd0) begin
         if (rd == 5'd0 && rs1f == 5'd0 && imm == 12'h000) begin
            is_trap = 1'b1;
            cause   = 5'd11;
         end else if (rd == 5'd0 && rs1f == 5'd0 && imm == 12'h001) begin
            is_trap = 1'b1;
            cause   = 5'd3;
         end else if (rd == 5'd0 && rs1f == 5'd0 && imm == 12'h302) begin
            r.redirect = 1'b1;
            r.next_pc  = m_mepc;
            m_mie_b    = m_mpie_b;
            m_mpie_b   = 1'b1;
         end else begin
            is_trap = 1'b1;
            cause   = 5'd2;
            tval    = ins;
         end
      end else if (opc == 7'h73 && f3[1:0] != 2'd0) begin
         wr_en = (f3[1:0] == 2'd1) || (rs1f != 5'd0);
         rd_en = !(f3[1:0] == 2'd1 && rd == 5'd0);
         known = ref_read(imm, q, old);
         ro    = (imm == CSR_MISA) || (imm == CSR_MIP) || (imm == CSR_MHARTID);
         if (!known || (wr_en && ro)) begin
            is_trap = 1'b1;
            cause   = 5'd2;
            tval    = ins;
         end else begin
            src = f3[2] ? {27'd0, rs1f} : rs1v;
            case (f3[1:0])
               2'd1:    nv = src;
               2'd2:    nv = old | src;
               default: nv = old & ~src;
            endcase
            if (wr_en) begin
               ref_write(imm, nv);
            end
            r.rd_we   = rd_en && (rd != 5'd0);
            r.rd_data = rd_en ? old : '0;
         end
      end else begin
         is_trap = 1'b1;
         cause   = 5'd2;
         tval    = ins;
      end
      if (is_trap) begin
         r.redirect = 1'b1;
         if (take_irq && m_mtvec[1:0] == 2'b01) begin
            r.next_pc = base + {25'd0, cause, 2'b00};
         end else begin
            r.next_pc = base;
         end
         m_mpie_b = m_mie_b;
         m_mie_b  = 1'b0;
         m_mepc   = {pc[31:2], 2'b00};
         m_mcause = {take_irq, 26'd0, cause};
         m_mtval  = tval;
      end
      return r;
   endfunction

   function automatic logic [31:0] csr_ins(input logic [2:0] f3, input csr_addr_t a,
                                           input logic [4:0] rs1, input logic [4:0] rd);
      return {a, rs1, f3, rd, 7'h73};
   endfunction

   //////////////////////////////////////////////////
   // drive and compare
   //////////////////////////////////////////////////
   task automatic check_equal(input string name, input sys_rsp_t exp, input sys_rsp_t act);
      if (exp !== act) begin
         $display("Fail %s expected %h actual %h", name, exp, act);
         $display("test failed");
         $fatal(1);
      end
   endtask

   task automatic run_cmd(input string name, input logic [31:0] ins, input xlen_t pc,
                          input xlen_t rs1v, input irq_t q);
      sys_rsp_t e;
      e = predict(ins, pc, rs1v, q);
      exp_q.push_back(e);
      name_q.push_back(name);
      cmd.valid     <= 1'b1;
      cmd.instr     <= ins;
      cmd.pc        <= pc;
      cmd.rs1_value <= rs1v;
      irq           <= q;
      do @(posedge clk); while (!cmd_ready);
      cmd.valid <= 1'b0;
      do @(posedge clk); while (!rsp.valid);
   endtask

   task automatic read_csr(input string name, input csr_addr_t a);
      run_cmd(name, csr_ins(F_RS, a, 5'd0, 5'd1), 32'h0000_1000, 32'd0, 3'b000);
   endtask

   always @(posedge clk) begin
      if (!rstn && rsp.valid) begin
         if (exp_q.size() == 0) begin
            $display("response arrived with no command outstanding");
            $display("test failed");
            $fatal(1);
         end else begin
            check_equal(name_q.pop_front(), exp_q.pop_front(), rsp);
         end
      end
   end

   // run limit
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles > LIMIT) begin
         $display("timeout: the run did not finish within %0d cycles", LIMIT);
         $display("test failed");
         $fatal(1);
      end
   end

   //////////////////////////////////////////////////
   // stimulus
   //////////////////////////////////////////////////
   initial begin
      csr_addr_t  wr_csrs[7];
      logic [2:0] f3s[6];
      csr_addr_t  a;
      irq_t       q;
      xlen_t      pc;
      clk       = 1'b0;
      rstn      = 1'b1;
      cmd       = '0;
      irq       = '0;
      cycles    = 0;
      wr_csrs   = '{CSR_MSTATUS, CSR_MIE, CSR_MTVEC, CSR_MSCRATCH,
                    CSR_MEPC, CSR_MCAUSE, CSR_MTVAL};
      f3s       = '{F_RW, F_RS, F_RC, F_RWI, F_RSI, F_RCI};
      m_mie_b    = 1'b0;
      m_mpie_b   = 1'b0;
      m_mie      = '0;
      m_mtvec    = '0;
      m_mscratch = '0;
      m_mepc     = '0;
      m_mcause   = '0;
      m_mtval    = '0;
      void'($urandom(83));
      repeat (5) @(posedge clk);
      rstn <= 1'b0;
      @(posedge clk);

      // random read-modify-write
      for (int i = 0; i < 200; i++) begin
         a = wr_csrs[$urandom % 7];
         run_cmd("random rmw", csr_ins(f3s[$urandom % 6], a, 5'($urandom), 5'($urandom)),
                 $urandom & 32'hffff_fffc, $urandom, 3'b000);
      end
      for (int i = 0; i < 7; i++) begin
         read_csr("rmw readback", wr_csrs[i]);
      end

      // suppression
      run_cmd("rw rd zero", csr_ins(F_RW, CSR_MSCRATCH, 5'd3, 5'd0), 32'h40, 32'h1234, 3'b000);
      run_cmd("rs rs1 zero", csr_ins(F_RS, CSR_MSCRATCH, 5'd0, 5'd4), 32'h44, 32'hffff, 3'b000);
      run_cmd("rsi uimm zero", csr_ins(F_RSI, CSR_MSCRATCH, 5'd0, 5'd4), 32'h48, 32'd0, 3'b000);
      run_cmd("rc rs1 zero", csr_ins(F_RC, CSR_MSCRATCH, 5'd0, 5'd5), 32'h4c, 32'hffff, 3'b000);
      read_csr("suppress readback", CSR_MSCRATCH);

      // illegal instructions
      run_cmd("set mtvec", csr_ins(F_RW, CSR_MTVEC, 5'd2, 5'd0), 32'h50, 32'h0000_3000, 3'b000);
      run_cmd("bad addr", csr_ins(F_RS, 12'h7c0, 5'd0, 5'd1), 32'h60, 32'd0, 3'b000);
      read_csr("bad addr mcause", CSR_MCAUSE);
      read_csr("bad addr mtval", CSR_MTVAL);
      run_cmd("write misa", csr_ins(F_RW, CSR_MISA, 5'd2, 5'd1), 32'h64, 32'h5, 3'b000);
      read_csr("misa mcause", CSR_MCAUSE);
      read_csr("misa mtval", CSR_MTVAL);
      run_cmd("write mip", csr_ins(F_RS, CSR_MIP, 5'd3, 5'd1), 32'h68, 32'h8, 3'b000);
      read_csr("mip mtval", CSR_MTVAL);
      run_cmd("write mhartid", csr_ins(F_RWI, CSR_MHARTID, 5'd1, 5'd1), 32'h6c, 32'd0, 3'b000);
      read_csr("mhartid mtval", CSR_MTVAL);
      run_cmd("non system", 32'h0020_80b3, 32'h70, 32'd0, 3'b000);
      read_csr("non system mcause", CSR_MCAUSE);
      read_csr("non system mtval", CSR_MTVAL);
      run_cmd("funct3 four", csr_ins(3'd4, CSR_MSTATUS, 5'd0, 5'd0), 32'h74, 32'd0, 3'b000);
      read_csr("funct3 four mtval", CSR_MTVAL);
      run_cmd("ecall with rd", 32'h0000_00f3, 32'h78, 32'd0, 3'b000);
      read_csr("ecall rd mtval", CSR_MTVAL);
      read_csr("read misa", CSR_MISA);
      read_csr("read mhartid", CSR_MHARTID);
      read_csr("read mip", CSR_MIP);

      // ecall, ebreak and mret
      run_cmd("mtvec base", csr_ins(F_RW, CSR_MTVEC, 5'd2, 5'd0), 32'h80, 32'h0000_4000, 3'b000);
      run_cmd("set mie bit", csr_ins(F_RSI, CSR_MSTATUS, 5'd8, 5'd0), 32'h84, 32'd0, 3'b000);
      run_cmd("ecall", I_ECALL, 32'h0000_0100, 32'd0, 3'b000);
      read_csr("ecall mstatus", CSR_MSTATUS);
      read_csr("ecall mcause", CSR_MCAUSE);
      run_cmd("mret after ecall", I_MRET, 32'h0000_4000, 32'd0, 3'b000);
      read_csr("mret mstatus", CSR_MSTATUS);
      // ebreak with MIE clear so the mret must bring back a zero
      run_cmd("clear mie bit", csr_ins(F_RCI, CSR_MSTATUS, 5'd8, 5'd0), 32'h88, 32'd0, 3'b000);
      run_cmd("ebreak", I_EBREAK, 32'h0000_0200, 32'd0, 3'b000);
      read_csr("ebreak mcause", CSR_MCAUSE);
      run_cmd("mret after ebreak", I_MRET, 32'h0000_4004, 32'd0, 3'b000);
      read_csr("ebreak mepc", CSR_MEPC);
      read_csr("ebreak mstatus", CSR_MSTATUS);

      // interrupts, vectored then direct
      run_cmd("vectored mtvec", csr_ins(F_RW, CSR_MTVEC, 5'd2, 5'd0), 32'h90, 32'h0000_2001,
              3'b000);
      run_cmd("enable lines", csr_ins(F_RW, CSR_MIE, 5'd2, 5'd0), 32'h94, 32'h0000_0888, 3'b000);
      for (int i = 0; i < 40; i++) begin
         if (i == 20) begin
            run_cmd("direct mtvec", csr_ins(F_RW, CSR_MTVEC, 5'd2, 5'd0), 32'h98,
                    32'h0000_2000, 3'b000);
         end
         run_cmd("irq enable", csr_ins(F_RSI, CSR_MSTATUS, 5'd8, 5'd0), 32'h9c, 32'd0, 3'b000);
         q  = irq_t'(3'($urandom));
         pc = $urandom & 32'hffff_fffc;
         run_cmd("irq take", csr_ins(F_RS, CSR_MSCRATCH, 5'd0, 5'd1), pc, 32'd0, q);
         read_csr("irq mepc", CSR_MEPC);
      end
      run_cmd("irq disable", csr_ins(F_RCI, CSR_MSTATUS, 5'd8, 5'd0), 32'ha0, 32'd0, 3'b000);
      run_cmd("masked irq", csr_ins(F_RS, CSR_MIP, 5'd0, 5'd2), 32'ha4, 32'd0, 3'b111);

      @(posedge clk);
      if (exp_q.size() == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

/* tb/priv_unit_sva.sv */
`timescale 1ns/1ps

module priv_unit_sva (
   input logic               clk,
   input logic               rstn,
   input logic               cmd_ready,
   input priv_pkg::sys_rsp_t rsp
);
   import priv_pkg::*;

   //////////////////////////////////////////////////
   // response strobe
   //////////////////////////////////////////////////
   // one cycle wide
   rsp_single: assert property (@(posedge clk) disable iff (rstn)
      rsp.valid |=> !rsp.valid)
      else $error("rsp.valid high on two consecutive cycles");

   // no new command while answering
   ready_low: assert property (@(posedge clk) disable iff (rstn)
      rsp.valid |-> !cmd_ready)
      else $error("cmd_ready high together with rsp.valid");

   // reset is active high here
   reset_quiet: assert property (@(posedge clk)
      rstn |=> !rsp.valid)
      else $error("rsp.valid high in the cycle after reset");

endmodule

bind priv_unit priv_unit_sva u_sva (
   .clk       (clk),
   .rstn      (rstn),
   .cmd_ready (cmd_ready),
   .rsp       (rsp)
);

/* hw/priv_unit.sv */
`timescale 1ns/1ps

module priv_unit #(
   parameter priv_pkg::xlen_t HART_ID    = 32'd0,
   parameter priv_pkg::xlen_t MISA_VALUE = 32'h4000_0100
) (
   input  logic               clk,
   input  logic               rstn,
   input  priv_pkg::sys_cmd_t cmd,
   input  priv_pkg::irq_t     irq,
   output logic               cmd_ready,
   output priv_pkg::sys_rsp_t rsp
);
   import priv_pkg::*;

   sys_op_e   op;
   logic      csr_read_en;
   logic      csr_write_en;
   logic      use_uimm;
   logic      irq_take;
   logic [4:0] irq_cause;
   csr_addr_t csr_addr;
   xlen_t     csr_wdata;
   logic      csr_we;
   xlen_t     rdata;
   logic      csr_valid;
   trap_req_t trap_req;
   logic      mret_req;
   logic      mstatus_mie;
   xlen_t     mie;
   xlen_t     mtvec;
   xlen_t     mepc;

   sys_decode u_decode (
      .instr        (cmd.instr),
      .op           (op),
      .csr_read_en  (csr_read_en),
      .csr_write_en (csr_write_en),
      .use_uimm     (use_uimm)
   );

   irq_arbiter u_irq (
      .irq         (irq),
      .mie         (mie),
      .mstatus_mie (mstatus_mie),
      .irq_take    (irq_take),
      .irq_cause   (irq_cause)
   );

   csr_file #(
      .HART_ID    (HART_ID),
      .MISA_VALUE (MISA_VALUE)
   ) u_csr (
      .clk         (clk),
      .rstn        (rstn),
      .addr        (csr_addr),
      .wdata       (csr_wdata),
      .we          (csr_we),
      .rdata       (rdata),
      .csr_valid   (csr_valid),
      .irq         (irq),
      .trap_req    (trap_req),
      .mret_req    (mret_req),
      .mstatus_mie (mstatus_mie),
      .mie         (mie),
      .mtvec       (mtvec),
      .mepc        (mepc)
   );

   priv_ctrl u_ctrl (
      .clk          (clk),
      .rstn         (rstn),
      .cmd          (cmd),
      .cmd_ready    (cmd_ready),
      .op           (op),
      .csr_read_en  (csr_read_en),
      .csr_write_en (csr_write_en),
      .use_uimm     (use_uimm),
      .irq_take     (irq_take),
      .irq_cause    (irq_cause),
      .rdata        (rdata),
      .csr_valid    (csr_valid),
      .mtvec        (mtvec),
      .mepc         (mepc),
      .csr_addr     (csr_addr),
      .csr_wdata    (csr_wdata),
      .csr_we       (csr_we),
      .trap_req     (trap_req),
      .mret_req     (mret_req),
      .rsp          (rsp)
   );

endmodule

/* hw/priv_ctrl.sv */
`timescale 1ns/1ps

module priv_ctrl (
   input  logic                clk,
   input  logic                rstn,
   input  priv_pkg::sys_cmd_t  cmd,
   output logic                cmd_ready,
   input  priv_pkg::sys_op_e   op,
   input  logic                csr_read_en,
   input  logic                csr_write_en,
   input  logic                use_uimm,
   input  logic                irq_take,
   input  logic [4:0]          irq_cause,
   input  priv_pkg::xlen_t     rdata,
   input  logic                csr_valid,
   input  priv_pkg::xlen_t     mtvec,
   input  priv_pkg::xlen_t     mepc,
   output priv_pkg::csr_addr_t csr_addr,
   output priv_pkg::xlen_t     csr_wdata,
   output logic                csr_we,
   output priv_pkg::trap_req_t trap_req,
   output logic                mret_req,
   output priv_pkg::sys_rsp_t  rsp
);
   import priv_pkg::*;

   typedef enum logic {IDLE, RESP} state_e;

   state_e   state_q;
   logic     accept;
   logic     illegal;
   logic     exec;
   xlen_t    src;
   xlen_t    tvec_base;
   xlen_t    trap_pc;
   sys_rsp_t rsp_next;

   assign cmd_ready = (state_q == IDLE);
   assign accept    = cmd.valid && cmd_ready;
   // an interrupt displaces the command
   assign exec      = accept && !irq_take;
   assign illegal   = (op == OP_ILLEGAL) || (op == OP_CSR && !csr_valid);

   //////////////////////////////////////////////////
   // csr new value
   //////////////////////////////////////////////////
   assign src      = use_uimm ? {27'd0, cmd.instr.csr_view.rs1_uimm} : cmd.rs1_value;
   assign csr_addr = cmd.instr.csr_view.csr;

   always_comb begin
      case (cmd.instr.csr_view.funct3[1:0])
         2'b10:   csr_wdata = rdata | src;
         2'b11:   csr_wdata = rdata & ~src;
         default: csr_wdata = src;
      endcase
   end

   assign csr_we   = exec && op == OP_CSR && csr_write_en;
   assign mret_req = exec && op == OP_MRET;

   always_comb begin
      trap_req.take   = accept && (irq_take || illegal || op == OP_ECALL || op == OP_EBREAK);
      trap_req.is_irq = irq_take;
      trap_req.epc    = cmd.pc;
      trap_req.tval   = '0;
      if (irq_take) begin
         trap_req.cause = irq_cause;
      end else if (illegal) begin
         trap_req.cause = CAUSE_ILLEGAL;
         trap_req.tval  = cmd.instr;
      end else if (op == OP_EBREAK) begin
         trap_req.cause = CAUSE_BREAK;
      end else begin
         trap_req.cause = CAUSE_ECALL_M;
      end
   end

   // vectored mode only applies to interrupts
   assign tvec_base = {mtvec[31:2], 2'b00};
   assign trap_pc   = (irq_take && mtvec[1:0] == 2'b01) ?
                      tvec_base + {25'd0, irq_cause, 2'b00} : tvec_base;

   //////////////////////////////////////////////////
   // response
   //////////////////////////////////////////////////
   always_comb begin
      rsp_next          = '0;
      rsp_next.valid    = 1'b1;
      rsp_next.rd_addr  = cmd.instr.csr_view.rd;
      rsp_next.next_pc  = cmd.pc + 32'd4;
      if (trap_req.take) begin
         rsp_next.redirect = 1'b1;
         rsp_next.next_pc  = trap_pc;
      end else if (op == OP_MRET) begin
         rsp_next.redirect = 1'b1;
         rsp_next.next_pc  = mepc;
      end else begin
         rsp_next.rd_we   = csr_read_en && cmd.instr.csr_view.rd != 5'd0;
         rsp_next.rd_data = csr_read_en ? rdata : '0;
      end
   end

   always_ff @(posedge clk) begin
      if (rstn) begin
         state_q <= IDLE;
         rsp     <= '0;
      end else begin
         rsp.valid <= accept;
         if (accept) begin
            state_q <= RESP;
            rsp     <= rsp_next;
         end else begin
            state_q <= IDLE;
         end
      end
   end

endmodule

/* hw/csr_file.sv */
`timescale 1ns/1ps

module csr_file #(
   parameter priv_pkg::xlen_t HART_ID    = 32'd0,
   parameter priv_pkg::xlen_t MISA_VALUE = 32'h4000_0100
) (
   input  logic                 clk,
   input  logic                 rstn,
   input  priv_pkg::csr_addr_t  addr,
   input  priv_pkg::xlen_t      wdata,
   input  logic                 we,
   output priv_pkg::xlen_t      rdata,
   output logic                 csr_valid,
   input  priv_pkg::irq_t       irq,
   input  priv_pkg::trap_req_t  trap_req,
   input  logic                 mret_req,
   output logic                 mstatus_mie,
   output priv_pkg::xlen_t      mie,
   output priv_pkg::xlen_t      mtvec,
   output priv_pkg::xlen_t      mepc
);
   import priv_pkg::*;

   logic  mstatus_mie_q;
   logic  mstatus_mpie_q;
   xlen_t mie_q;
   xlen_t mtvec_q;
   xlen_t mscratch_q;
   xlen_t mepc_q;
   xlen_t mcause_q;
   xlen_t mtval_q;

   xlen_t mstatus_rd;
   xlen_t mip_rd;
   logic  known;
   logic  read_only;

   //////////////////////////////////////////////////
   // read side
   //////////////////////////////////////////////////
   always_comb begin
      mstatus_rd               = MSTATUS_MPP;
      mstatus_rd[MSTATUS_MIE]  = mstatus_mie_q;
      mstatus_rd[MSTATUS_MPIE] = mstatus_mpie_q;
   end

   // mip mirrors the live lines
   always_comb begin
      mip_rd            = '0;
      mip_rd[IRQ_SW]    = irq.sw;
      mip_rd[IRQ_TIMER] = irq.timer;
      mip_rd[IRQ_EXT]   = irq.ext;
   end

   always_comb begin
      rdata     = '0;
      known     = 1'b1;
      read_only = 1'b0;
      case (addr)
         CSR_MSTATUS:  rdata = mstatus_rd;
         CSR_MISA: begin
            rdata     = MISA_VALUE;
            read_only = 1'b1;
         end
         CSR_MIE:      rdata = mie_q;
         CSR_MTVEC:    rdata = mtvec_q;
         CSR_MSCRATCH: rdata = mscratch_q;
         CSR_MEPC:     rdata = mepc_q;
         CSR_MCAUSE:   rdata = mcause_q;
         CSR_MTVAL:    rdata = mtval_q;
         CSR_MIP: begin
            rdata     = mip_rd;
            read_only = 1'b1;
         end
         CSR_MHARTID: begin
            rdata     = HART_ID;
            read_only = 1'b1;
         end
         default:      known = 1'b0;
      endcase
   end

   assign csr_valid = known && !(we && read_only);

   //////////////////////////////////////////////////
   // update side
   //////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (rstn) begin
         mstatus_mie_q  <= 1'b0;
         mstatus_mpie_q <= 1'b0;
         mie_q          <= '0;
         mtvec_q        <= '0;
         mscratch_q     <= '0;
         mepc_q         <= '0;
         mcause_q       <= '0;
         mtval_q        <= '0;
      end else if (trap_req.take) begin
         mstatus_mpie_q <= mstatus_mie_q;
         mstatus_mie_q  <= 1'b0;
         mepc_q         <= {trap_req.epc[31:2], 2'b00};
         mcause_q       <= {trap_req.is_irq, 26'd0, trap_req.cause};
         mtval_q        <= trap_req.tval;
      end else if (mret_req) begin
         mstatus_mie_q  <= mstatus_mpie_q;
         mstatus_mpie_q <= 1'b1;
      end else if (we && csr_valid) begin
         case (addr)
            CSR_MSTATUS: begin
               mstatus_mie_q  <= wdata[MSTATUS_MIE];
               mstatus_mpie_q <= wdata[MSTATUS_MPIE];
            end
            CSR_MIE:      mie_q <= wdata & MIE_MASK;
            CSR_MTVEC: begin
               // modes 2 and 3 are reserved, keep the old value
               if (!wdata[1]) begin
                  mtvec_q <= wdata;
               end
            end
            CSR_MSCRATCH: mscratch_q <= wdata;
            CSR_MEPC:     mepc_q     <= {wdata[31:2], 2'b00};
            CSR_MCAUSE:   mcause_q   <= wdata;
            CSR_MTVAL:    mtval_q    <= wdata;
            default: begin
            end
         endcase
      end
   end

   assign mstatus_mie = mstatus_mie_q;
   assign mie         = mie_q;
   assign mtvec       = mtvec_q;
   assign mepc        = mepc_q;

endmodule

/* hw/irq_arbiter.sv */
`timescale 1ns/1ps

module irq_arbiter (
   input  priv_pkg::irq_t  irq,
   input  priv_pkg::xlen_t mie,
   input  logic            mstatus_mie,
   output logic            irq_take,
   output logic [4:0]      irq_cause
);
   import priv_pkg::*;

   logic pend_ext;
   logic pend_sw;
   logic pend_timer;

   // pending means line high, enabled, and global enable set
   assign pend_ext   = irq.ext   && mie[IRQ_EXT]   && mstatus_mie;
   assign pend_sw    = irq.sw    && mie[IRQ_SW]    && mstatus_mie;
   assign pend_timer = irq.timer && mie[IRQ_TIMER] && mstatus_mie;

   assign irq_take = pend_ext || pend_sw || pend_timer;

   // ext beats sw beats timer
   always_comb begin
      if (pend_ext) begin
         irq_cause = IRQ_EXT;
      end else if (pend_sw) begin
         irq_cause = IRQ_SW;
      end else if (pend_timer) begin
         irq_cause = IRQ_TIMER;
      end else begin
         irq_cause = 5'd0;
      end
   end

endmodule

/* hw/sys_decode.sv */
`timescale 1ns/1ps

module sys_decode (
   input  priv_pkg::sys_instr_u instr,
   output priv_pkg::sys_op_e    op,
   output logic                 csr_read_en,
   output logic                 csr_write_en,
   output logic                 use_uimm
);
   import priv_pkg::*;

   logic is_system;
   logic no_regs;
   logic [1:0] csr_kind;

   assign is_system = (instr.priv_view.opcode == OPC_SYSTEM);
   // ecall, ebreak and mret all have rd and rs1 zero
   assign no_regs   = (instr.priv_view.rd == 5'd0) && (instr.priv_view.rs1 == 5'd0);
   // 01 rw, 10 rs, 11 rc
   assign csr_kind  = instr.csr_view.funct3[1:0];
   assign use_uimm  = instr.csr_view.funct3[2];

   always_comb begin
      op           = OP_ILLEGAL;
      csr_read_en  = 1'b0;
      csr_write_en = 1'b0;
      if (is_system) begin
         if (instr.priv_view.funct3 == 3'b000) begin
            if (no_regs && instr.priv_view.funct7 == 7'd0 && instr.priv_view.rs2 == 5'd0) begin
               op = OP_ECALL;
            end else if (no_regs && instr.priv_view.funct7 == 7'd0
                         && instr.priv_view.rs2 == 5'd1) begin
               op = OP_EBREAK;
            end else if (no_regs && instr.priv_view.funct7 == FUNCT7_MRET
                         && instr.priv_view.rs2 == 5'd2) begin
               op = OP_MRET;
            end
         end else if (csr_kind != 2'b00) begin
            op = OP_CSR;
            // csrrw/csrrwi to x0 skip the read
            csr_read_en  = !(csr_kind == 2'b01 && instr.csr_view.rd == 5'd0);
            // set/clear with a zero source skip the write
            csr_write_en = !(csr_kind != 2'b01 && instr.csr_view.rs1_uimm == 5'd0);
         end
      end
   end

endmodule

/* hw/priv_pkg.sv */
package priv_pkg;

   typedef logic [31:0] xlen_t;
   typedef logic [11:0] csr_addr_t;

   //////////////////////////////////////////////////
   // machine CSR addresses
   //////////////////////////////////////////////////
   localparam csr_addr_t CSR_MSTATUS  = 12'h300;
   localparam csr_addr_t CSR_MISA     = 12'h301;
   localparam csr_addr_t CSR_MIE      = 12'h304;
   localparam csr_addr_t CSR_MTVEC    = 12'h305;
   localparam csr_addr_t CSR_MSCRATCH = 12'h340;
   localparam csr_addr_t CSR_MEPC     = 12'h341;
   localparam csr_addr_t CSR_MCAUSE   = 12'h342;
   localparam csr_addr_t CSR_MTVAL    = 12'h343;
   localparam csr_addr_t CSR_MIP      = 12'h344;
   localparam csr_addr_t CSR_MHARTID  = 12'hf14;

   // exception causes
   localparam logic [4:0] CAUSE_ILLEGAL = 5'd2;
   localparam logic [4:0] CAUSE_BREAK   = 5'd3;
   localparam logic [4:0] CAUSE_ECALL_M = 5'd11;

   // interrupt causes, also the mip/mie bit index
   localparam logic [4:0] IRQ_SW    = 5'd3;
   localparam logic [4:0] IRQ_TIMER = 5'd7;
   localparam logic [4:0] IRQ_EXT   = 5'd11;

   // mstatus fields
   localparam int    MSTATUS_MIE  = 3;
   localparam int    MSTATUS_MPIE = 7;
   localparam xlen_t MSTATUS_MPP  = 32'h0000_1800;

   localparam xlen_t MIE_MASK = 32'h0000_0888;

   localparam logic [6:0] OPC_SYSTEM  = 7'b1110011;
   localparam logic [6:0] FUNCT7_MRET = 7'b0011000;

   //////////////////////////////////////////////////
   // instruction word, two decodings
   //////////////////////////////////////////////////
   typedef struct packed {
      csr_addr_t  csr;
      logic [4:0] rs1_uimm;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } csr_view_t;

   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } priv_view_t;

   typedef union packed {
      csr_view_t  csr_view;
      priv_view_t priv_view;
   } sys_instr_u;

   typedef enum logic [2:0] {
      OP_CSR,
      OP_ECALL,
      OP_EBREAK,
      OP_MRET,
      OP_ILLEGAL
   } sys_op_e;

   typedef struct packed {
      logic       valid;
      sys_instr_u instr;
      xlen_t      pc;
      xlen_t      rs1_value;
   } sys_cmd_t;

   typedef struct packed {
      logic       valid;
      logic       rd_we;
      logic [4:0] rd_addr;
      xlen_t      rd_data;
      logic       redirect;
      xlen_t      next_pc;
   } sys_rsp_t;

   typedef struct packed {
      logic ext;
      logic sw;
      logic timer;
   } irq_t;

   typedef struct packed {
      logic       take;
      logic       is_irq;
      logic [4:0] cause;
      xlen_t      epc;
      xlen_t      tval;
   } trap_req_t;

endpackage
